/* gpio_consts.svh */
// GPIO defaults: pin count, synchronizer depth, bus data and address widths
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

////////////////////
// Pin side
////////////////////

// Default number of GPIO pins
`define GPIO_GDW 8
// Synchronizer stages on pin inputs
`define GPIO_CDC 2

////////////////////
// Bus side
////////////////////

// Wishbone data width
`define GPIO_WB_DW 32
// Wishbone word address width
`define GPIO_WB_AW 3

`endif

/* gpio_pkg.sv */
// GPIO package: register address enum and Wishbone slave state enum
package gpio_pkg;

    ////////////////////
    // Register map
    ////////////////////

    // Word addresses of the register file
    typedef enum logic [2:0] {
        REG_OUT  = 3'd0,  // pin output values
        REG_ENA  = 3'd1,  // pin output enables
        REG_IN   = 3'd2,  // synchronized pin inputs, read only
        REG_RISE = 3'd3,  // rising edge irq enables
        REG_FALL = 3'd4,  // falling edge irq enables
        REG_PEND = 3'd5,  // pending irq bits, write one to clear
        REG_NONE = 3'd6   // unmapped, covers 6 and 7
    } gpio_reg_e;

    ////////////////////
    // Bus slave FSM
    ////////////////////

    // Idle, or acknowledging a sampled request
    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

/* gpio_wb_slave.sv */
// Wishbone classic slave: registered ack FSM, address decode, write and read strobes
`include "gpio_consts.svh"

module gpio_wb_slave (
    input  logic                      clk,
    input  logic                      rst_n,
    // Wishbone request
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`GPIO_WB_AW-1:0]    wb_adr,
    // Wishbone response
    output logic                      wb_ack,
    // Register file access
    output gpio_pkg::gpio_reg_e       reg_sel,
    output logic                      wr_stb,
    output logic                      rd_stb
);

    import gpio_pkg::*;

    // Highest mapped word address
    localparam logic [`GPIO_WB_AW-1:0] last_adr = `GPIO_WB_AW'(REG_PEND);

    wb_state_e state_q;
    wb_state_e state_d;
    logic      req;

    ////////////////////
    // Ack FSM
    ////////////////////

    // Valid request from the master
    assign req = wb_cyc & wb_stb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                // Sample request, ack next cycle
                if (req) begin
                    state_d = WB_ACK;
                end
            end
            WB_ACK: begin
                // Single ack cycle, then back to idle
                state_d = WB_IDLE;
            end
            default: state_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Ack straight from the state register
    assign wb_ack = (state_q == WB_ACK);

    ////////////////////
    // Decode
    ////////////////////

    // Master holds adr until ack, so decode is combinational
    assign reg_sel = (wb_adr > last_adr) ? REG_NONE : gpio_reg_e'(wb_adr);

    // Strobes only in the ack cycle
    assign wr_stb = wb_ack & req & wb_we;
    assign rd_stb = wb_ack & req & ~wb_we;

    // Ack is a single pulse per access
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

/* gpio_input_sync.sv */
// Pin input synchronizer chain with registered rising and falling edge pulses
`include "gpio_consts.svh"

module gpio_input_sync #(
    parameter int unsigned gdw = `GPIO_GDW,  // pin count
    parameter int unsigned cdc = `GPIO_CDC   // synchronizer stages
) (
    input  logic           clk,
    input  logic           rst_n,
    // Asynchronous pins
    input  logic [gdw-1:0] gpio_in,
    // Synchronized pins and edge pulses
    output logic [gdw-1:0] pin_sync,
    output logic [gdw-1:0] rise,
    output logic [gdw-1:0] fall
);

    // Synchronizer stages, stage 0 samples the pins
    logic [cdc-1:0][gdw-1:0] sync_q;
    // Previous synchronized value
    logic [gdw-1:0]          prev_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
            prev_q <= '0;
            rise   <= '0;
            fall   <= '0;
        end else begin
            sync_q[0] <= gpio_in;
            for (int i = 1; i < cdc; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= pin_sync;
            // Edge pulses one cycle after pin_sync changes
            rise   <= pin_sync & ~prev_q;
            fall   <= ~pin_sync & prev_q;
        end
    end

    // Last stage is the visible pin value
    assign pin_sync = sync_q[cdc-1];

    // A bit cannot rise and fall at once
    a_edge_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (rise & fall) == '0);

endmodule

/* gpio_regs.sv */
// GPIO register file: OUT, ENA, RISE, FALL registers, read mux and pending clear mask
`include "gpio_consts.svh"

module gpio_regs #(
    parameter int unsigned gdw = `GPIO_GDW  // pin count
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Bus side access
    input  gpio_pkg::gpio_reg_e     reg_sel,
    input  logic                    wr_stb,
    input  logic                    rd_stb,
    input  logic [`GPIO_WB_DW-1:0]  wr_dat,
    output logic [`GPIO_WB_DW-1:0]  rd_dat,
    // Pin and irq status
    input  logic [gdw-1:0]          pin_sync,
    input  logic [gdw-1:0]          pend,
    // Pin drivers
    output logic [gdw-1:0]          gpio_out,
    output logic [gdw-1:0]          gpio_oe,
    // Irq controller config
    output logic [gdw-1:0]          rise_en,
    output logic [gdw-1:0]          fall_en,
    output logic [gdw-1:0]          pend_clr
);

    import gpio_pkg::*;

    logic [`GPIO_WB_DW-1:0] rd_mux;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
            rise_en  <= '0;
            fall_en  <= '0;
        end else if (wr_stb) begin
            case (reg_sel)
                REG_OUT:  gpio_out <= wr_dat[gdw-1:0];
                REG_ENA:  gpio_oe  <= wr_dat[gdw-1:0];
                REG_RISE: rise_en  <= wr_dat[gdw-1:0];
                REG_FALL: fall_en  <= wr_dat[gdw-1:0];
                // IN is read only, PEND handled by irq ctrl, NONE dropped
                default: ;
            endcase
        end
    end

    // Write one to clear, only during a PEND write
    assign pend_clr = (wr_stb && reg_sel == REG_PEND) ? wr_dat[gdw-1:0] : '0;

    ////////////////////
    // Read side
    ////////////////////

    // Zero extended to bus width
    always_comb begin
        rd_mux = '0;
        case (reg_sel)
            REG_OUT:  rd_mux[gdw-1:0] = gpio_out;
            REG_ENA:  rd_mux[gdw-1:0] = gpio_oe;
            REG_IN:   rd_mux[gdw-1:0] = pin_sync;
            REG_RISE: rd_mux[gdw-1:0] = rise_en;
            REG_FALL: rd_mux[gdw-1:0] = fall_en;
            REG_PEND: rd_mux[gdw-1:0] = pend;
            default:  rd_mux = '0;
        endcase
    end

    // Data only driven in the read ack cycle
    assign rd_dat = rd_stb ? rd_mux : '0;

endmodule

/* gpio_irq_ctrl.sv */
// GPIO interrupt controller: edge-set, write-one-clear pending bits and combined irq
`include "gpio_consts.svh"

module gpio_irq_ctrl #(
    parameter int unsigned gdw = `GPIO_GDW  // pin count
) (
    input  logic           clk,
    input  logic           rst_n,
    // Edge pulses from the synchronizer
    input  logic [gdw-1:0] rise,
    input  logic [gdw-1:0] fall,
    // Config from the register file
    input  logic [gdw-1:0] rise_en,
    input  logic [gdw-1:0] fall_en,
    input  logic [gdw-1:0] pend_clr,
    // Status and request
    output logic [gdw-1:0] pend,
    output logic           irq
);

    logic [gdw-1:0] pend_set;

    ////////////////////
    // Pending bits
    ////////////////////

    // Enabled edges only
    assign pend_set = (rise & rise_en) | (fall & fall_en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            // Set applied after clear, so set wins
            pend <= (pend & ~pend_clr) | pend_set;
        end
    end

    ////////////////////
    // Request line
    ////////////////////

    // Any pending bit raises irq
    assign irq = |pend;

    // irq tracks the pending bits
    a_irq_pend: assert property (@(posedge clk) disable iff (!rst_n)
        irq == (pend != '0));

endmodule

/* gpio_wb_top.sv */
// GPIO top level: Wishbone slave, pin synchronizer, register file and irq controller
`include "gpio_consts.svh"

module gpio_wb_top #(
    parameter int unsigned gdw = `GPIO_GDW  // pin count
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Wishbone classic slave
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`GPIO_WB_AW-1:0]  wb_adr,
    input  logic [`GPIO_WB_DW-1:0]  wb_dat_w,
    output logic [`GPIO_WB_DW-1:0]  wb_dat_r,
    output logic                    wb_ack,
    // Pins
    input  logic [gdw-1:0]          gpio_in,
    output logic [gdw-1:0]          gpio_out,
    output logic [gdw-1:0]          gpio_oe,
    // Interrupt
    output logic                    irq
);

    import gpio_pkg::*;

    // Bus to register file
    gpio_reg_e      reg_sel;
    logic           wr_stb;
    logic           rd_stb;
    // Synchronizer outputs
    logic [gdw-1:0] pin_sync;
    logic [gdw-1:0] rise;
    logic [gdw-1:0] fall;
    // Register file to irq ctrl and back
    logic [gdw-1:0] rise_en;
    logic [gdw-1:0] fall_en;
    logic [gdw-1:0] pend_clr;
    logic [gdw-1:0] pend;

    gpio_wb_slave i_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_ack  (wb_ack),
        .reg_sel (reg_sel),
        .wr_stb  (wr_stb),
        .rd_stb  (rd_stb)
    );

    gpio_input_sync #(
        .gdw (gdw),
        .cdc (`GPIO_CDC)
    ) i_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .gpio_in  (gpio_in),
        .pin_sync (pin_sync),
        .rise     (rise),
        .fall     (fall)
    );

    // Write data is held by the master through ack
    gpio_regs #(
        .gdw (gdw)
    ) i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_sel  (reg_sel),
        .wr_stb   (wr_stb),
        .rd_stb   (rd_stb),
        .wr_dat   (wb_dat_w),
        .rd_dat   (wb_dat_r),
        .pin_sync (pin_sync),
        .pend     (pend),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .rise_en  (rise_en),
        .fall_en  (fall_en),
        .pend_clr (pend_clr)
    );

    gpio_irq_ctrl #(
        .gdw (gdw)
    ) i_irq (
        .clk      (clk),
        .rst_n    (rst_n),
        .rise     (rise),
        .fall     (fall),
        .rise_en  (rise_en),
        .fall_en  (fall_en),
        .pend_clr (pend_clr),
        .pend     (pend),
        .irq      (irq)
    );

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset generator
module tb_clk_gen #(
    parameter int half_period = 20  // period of 40
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset low for two cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* gpio_tb.sv */
// GPIO testbench: table of Wishbone accesses and pin changes with output checks
`include "gpio_consts.svh"

module gpio_tb;

    localparam int gdw = `GPIO_GDW;
    // Cycles allowed for ack and for reset release
    localparam int wait_limit = 10;
    localparam logic [`GPIO_WB_DW-1:0] pin_mask = (1 << gdw) - 1;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PIN} op_e;

    // One table row
    typedef struct packed {
        op_e                    op;
        logic [`GPIO_WB_AW-1:0] adr;
        logic [`GPIO_WB_DW-1:0] dat;
        logic [`GPIO_WB_DW-1:0] exp;
        logic                   exp_irq;
    } entry_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`GPIO_WB_AW-1:0] wb_adr;
    logic [`GPIO_WB_DW-1:0] wb_dat_w;
    logic [`GPIO_WB_DW-1:0] wb_dat_r;
    logic                   wb_ack;
    logic [gdw-1:0]         gpio_in;
    logic [gdw-1:0]         gpio_out;
    logic [gdw-1:0]         gpio_oe;
    logic                   irq;

    entry_t         table_q[$];
    integer         seed;
    // Expected pin drivers
    logic [gdw-1:0] out_model;
    logic [gdw-1:0] oe_model;

    tb_clk_gen i_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gpio_wb_top #(
        .gdw (gdw)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .irq      (irq)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic add_entry(input op_e op, input logic [`GPIO_WB_AW-1:0] adr,
                             input logic [`GPIO_WB_DW-1:0] dat,
                             input logic [`GPIO_WB_DW-1:0] exp, input logic exp_irq);
        entry_t e;
        e.op      = op;
        e.adr     = adr;
        e.dat     = dat;
        e.exp     = exp;
        e.exp_irq = exp_irq;
        table_q.push_back(e);
    endtask

    // One classic access, starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input logic [`GPIO_WB_AW-1:0] adr,
                             input logic [`GPIO_WB_DW-1:0] dat,
                             output logic [`GPIO_WB_DW-1:0] rd);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < wait_limit);
        if (!wb_ack) begin
            abort_run($sformatf("Timeout: no ack for the access to address %0d", adr));
        end
        assert (waited == 1) else
            abort_run($sformatf("Error: ack latency expected 0x1, actual 0x%h", waited));
        rd = wb_dat_r;
        // Request held through the ack cycle
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        assert (wb_ack === 1'b0) else
            abort_run($sformatf("Error: wb_ack expected 0x0, actual 0x%h", wb_ack));
        assert (i_dut.i_slave.state_q == gpio_pkg::WB_IDLE) else
            abort_run($sformatf("Error: state_q expected 0x%h, actual 0x%h",
                                gpio_pkg::WB_IDLE, i_dut.i_slave.state_q));
    endtask

    // Synchronizer, edge pulse and pending bit all settle in this window
    task automatic set_pins(input logic [gdw-1:0] value);
        gpio_in = value;
        repeat (`GPIO_CDC + 3) @(negedge clk);
    endtask

    task automatic check_outputs(input logic exp_irq);
        assert (gpio_out === out_model) else
            abort_run($sformatf("Error: gpio_out expected 0x%h, actual 0x%h", out_model, gpio_out));
        assert (gpio_oe === oe_model) else
            abort_run($sformatf("Error: gpio_oe expected 0x%h, actual 0x%h", oe_model, gpio_oe));
        assert (irq === exp_irq) else
            abort_run($sformatf("Error: irq expected 0x%h, actual 0x%h", exp_irq, irq));
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic load_table();
        logic [`GPIO_WB_DW-1:0] rnd_out;
        logic [`GPIO_WB_DW-1:0] rnd_oe;
        rnd_out = $random(seed);
        rnd_oe  = $random(seed);
        // Reset values of all readable registers
        for (int a = 0; a < 6; a++) begin
            add_entry(OP_RD, 3'(a), '0, '0, 1'b0);
        end
        // Output and enable, then ignored writes
        add_entry(OP_WR, 3'd0, rnd_out, '0, 1'b0);
        add_entry(OP_RD, 3'd0, '0, rnd_out & pin_mask, 1'b0);
        add_entry(OP_WR, 3'd1, rnd_oe, '0, 1'b0);
        add_entry(OP_RD, 3'd1, '0, rnd_oe & pin_mask, 1'b0);
        add_entry(OP_WR, 3'd2, 32'h0000_00ff, '0, 1'b0);
        add_entry(OP_WR, 3'd6, 32'hffff_ffff, '0, 1'b0);
        add_entry(OP_RD, 3'd0, '0, rnd_out & pin_mask, 1'b0);
        add_entry(OP_RD, 3'd1, '0, rnd_oe & pin_mask, 1'b0);
        add_entry(OP_RD, 3'd2, '0, '0, 1'b0);
        add_entry(OP_RD, 3'd7, '0, '0, 1'b0);
        // Pin read back, no edge armed
        add_entry(OP_PIN, 3'd0, 32'h20, '0, 1'b0);
        add_entry(OP_RD, 3'd2, '0, 32'h20, 1'b0);
        add_entry(OP_RD, 3'd5, '0, '0, 1'b0);
        // Rise on pin 2 armed, fall on pin 5 not armed
        add_entry(OP_WR, 3'd3, 32'h04, '0, 1'b0);
        add_entry(OP_PIN, 3'd0, 32'h24, '0, 1'b1);
        add_entry(OP_RD, 3'd5, '0, 32'h04, 1'b1);
        add_entry(OP_PIN, 3'd0, 32'h04, '0, 1'b1);
        add_entry(OP_RD, 3'd5, '0, 32'h04, 1'b1);
        // Clear pin 2, then arm fall on pin 5
        add_entry(OP_WR, 3'd5, 32'h04, '0, 1'b0);
        add_entry(OP_RD, 3'd5, '0, '0, 1'b0);
        add_entry(OP_WR, 3'd4, 32'h20, '0, 1'b0);
        add_entry(OP_PIN, 3'd0, 32'h24, '0, 1'b0);
        add_entry(OP_PIN, 3'd0, 32'h04, '0, 1'b1);
        add_entry(OP_RD, 3'd5, '0, 32'h20, 1'b1);
        add_entry(OP_RD, 3'd3, '0, 32'h04, 1'b1);
        add_entry(OP_RD, 3'd4, '0, 32'h20, 1'b1);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int                     waited;
        entry_t                 e;
        logic [`GPIO_WB_DW-1:0] rd;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        gpio_in   = '0;
        out_model = '0;
        oe_model  = '0;
        seed      = 32'h722e_aff8;
        load_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("Timeout: reset was never released");
        end
        check_outputs(1'b0);
        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            case (e.op)
                OP_WR: begin
                    bus_cycle(1'b1, e.adr, e.dat, rd);
                    if (e.adr == 3'd0) begin
                        out_model = e.dat[gdw-1:0];
                    end
                    if (e.adr == 3'd1) begin
                        oe_model = e.dat[gdw-1:0];
                    end
                end
                OP_RD: begin
                    bus_cycle(1'b0, e.adr, '0, rd);
                    assert (rd === e.exp) else
                        abort_run($sformatf("Error: wb_dat_r at address %0d expected 0x%h, actual 0x%h",
                                            e.adr, e.exp, rd));
                end
                default: set_pins(e.dat[gdw-1:0]);
            endcase
            check_outputs(e.exp_irq);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
gpio_pkg.sv
gpio_wb_slave.sv
gpio_input_sync.sv
gpio_regs.sv
gpio_irq_ctrl.sv
gpio_wb_top.sv
tb_clk_gen.sv
gpio_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
